/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_mem_top
FILELIST = sources.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

# the log decides pass or fail
sim: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* mem_bus_if.sv */
`timescale 1ns/1ps

// 16-bit on-chip ram bus, no wait states
interface mem_bus_if;

    mem_pkg::addr_t addr;   // byte address, word taken from addr[23:1]
    mem_pkg::half_t din;
    mem_pkg::half_t dout;   // same-cycle read data
    logic [1:0]     we;     // lane mask, [1] upper byte

    // controller side
    modport ctl (
        output addr,
        output din,
        output we,
        input  dout
    );

    // memory side
    modport mem (
        input  addr,
        input  din,
        input  we,
        output dout
    );

endinterface

/* mem_cfg_apb.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_cfg_apb (
    input  logic              clk,
    input  logic              rst,
    input  logic [`CFG_AW-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    input  logic              wr_cycle,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              cen
);

    mem_pkg::ctrl_t ctrl;
    logic [31:0]    wr_cnt;     // ram write cycles seen
    logic [3:0]     div_cnt;
    logic           setup;
    logic           access;
    logic           hit_ctrl;
    logic           hit_cnt;

    assign setup    = psel && !penable;
    assign access   = psel && penable;
    assign hit_ctrl = paddr == `CFG_CTRL;
    assign hit_cnt  = paddr == `CFG_WRCNT;
    assign pready   = 1'b1;
    assign cen      = ctrl.enable && div_cnt == 4'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl   <= mem_pkg::CTRL_RESET;
            wr_cnt <= 32'd0;
        end else begin
            if (access && pwrite && hit_ctrl)
                ctrl <= mem_pkg::ctrl_t'(pwdata[$bits(mem_pkg::ctrl_t)-1:0]);
            if (access && pwrite && hit_cnt)
                wr_cnt <= 32'd0;        // any write clears
            else if (wr_cycle)
                wr_cnt <= wr_cnt + 32'd1;
        end
    end

    // read data ready for the access phase
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prdata  <= 32'd0;
            pslverr <= 1'b0;
        end else if (setup) begin
            pslverr <= !(hit_ctrl || hit_cnt);
            if (!pwrite && hit_ctrl)
                prdata <= 32'(ctrl);
            else if (!pwrite && hit_cnt)
                prdata <= wr_cnt;
            else
                prdata <= 32'd0;
        end else if (!access) begin
            prdata  <= 32'd0;
            pslverr <= 1'b0;
        end
    end

    // clock enable divider
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            div_cnt <= 4'd0;
        else if (!ctrl.enable)
            div_cnt <= 4'd0;    // restart at once when enabled
        else if (div_cnt == 4'd0)
            div_cnt <= ctrl.div;
        else
            div_cnt <= div_cnt - 4'd1;
    end

    // access phase always comes right after a setup phase
    a_penable_after_psel: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> psel && $past(psel));

endmodule

/* mem_macros.svh */
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// cpu byte address width
`define MEM_AW 24

// on-chip ram size in 16-bit words
`define MEM_DEPTH_WORDS 2048

// apb register map
`define CFG_AW    8
`define CFG_CTRL  8'h00
`define CFG_WRCNT 8'h04

`endif

/* mem_pkg.sv */
`include "mem_macros.svh"

package mem_pkg;

    // byte address as seen by the cpu
    typedef logic [`MEM_AW-1:0] addr_t;

    // one ram word, byte lanes [15:8] odd and [7:0] even
    typedef logic [15:0] half_t;

    // cpu data, lowest address in [7:0]
    typedef logic [31:0] long_t;

    // access length, one-hot
    typedef logic [2:0] len_t;

    localparam len_t LEN_BYTE = 3'b001;
    localparam len_t LEN_WORD = 3'b010;
    localparam len_t LEN_LONG = 3'b100;

    // CTRL register layout, enable sits in bit 0
    typedef struct packed {
        logic [3:0] div;    // cen every div+1 clocks
        logic       enable;
    } ctrl_t;

    localparam ctrl_t CTRL_RESET = '{div: 4'd0, enable: 1'b1};

endpackage

/* mem_top.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_top (
    input  logic               clk,
    input  logic               rst,
    // cpu side
    input  mem_pkg::addr_t     pc,
    input  mem_pkg::addr_t     idx_addr,
    input  mem_pkg::addr_t     xsp,
    input  logic               ldram_en,
    input  logic               sel_xsp,
    input  logic               data_sel,
    input  mem_pkg::long_t     alu_dout,
    input  logic               idx_wr,
    input  mem_pkg::len_t      len,
    output mem_pkg::long_t     dout,
    output logic               ram_rdy,
    // apb
    input  logic [`CFG_AW-1:0] paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);

    logic cen;
    logic wr_cycle;

    mem_bus_if ram_bus ();

    ram_ctl u_ram_ctl (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ldram_en (ldram_en),
        .idx_addr (idx_addr),
        .xsp      (xsp),
        .pc       (pc),
        .sel_xsp  (sel_xsp),
        .data_sel (data_sel),
        .alu_dout (alu_dout),
        .idx_wr   (idx_wr),
        .len      (len),
        .dout     (dout),
        .ram_rdy  (ram_rdy),
        .wr_cycle (wr_cycle),
        .bus      (ram_bus.ctl)
    );

    sram16 u_sram16 (
        .clk (clk),
        .bus (ram_bus.mem)
    );

    mem_cfg_apb u_cfg (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .wr_cycle (wr_cycle),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .cen      (cen)
    );

endmodule

/* ram_ctl.sv */
`timescale 1ns/1ps

module ram_ctl (
    input  logic           clk,
    input  logic           rst,
    input  logic           cen,
    input  logic           ldram_en,
    input  mem_pkg::addr_t idx_addr,
    input  mem_pkg::addr_t xsp,
    input  mem_pkg::addr_t pc,
    input  logic           sel_xsp,
    input  logic           data_sel,
    input  mem_pkg::long_t alu_dout,
    input  logic           idx_wr,
    input  mem_pkg::len_t  len,
    output mem_pkg::long_t dout,
    output logic           ram_rdy,
    output logic           wr_cycle,
    mem_bus_if.ctl         bus
);

    mem_pkg::addr_t req_addr;
    mem_pkg::addr_t eff_addr;
    mem_pkg::long_t eff_data;

    // read window of four bytes from win_addr on
    mem_pkg::addr_t win_addr;
    mem_pkg::half_t win_lo;     // bytes 0 and 1
    mem_pkg::half_t win_hi;     // bytes 2 and 3
    logic [3:0]     win_ok;
    logic [3:0]     fill;       // bytes still waiting for ram
    mem_pkg::addr_t fetch_addr;
    logic [3:0]     got;
    logic [7:0]     lane [4];
    logic           hit;
    logic           rd_go;
    logic           slide1, slide2, slide3;

    // write splitter
    logic           wr_start;
    logic           wr_busy;
    logic [1:0]     wr_step;
    logic [1:0]     wr_last;
    mem_pkg::addr_t wr_addr;
    mem_pkg::long_t wr_data;
    mem_pkg::len_t  wr_len;
    mem_pkg::half_t wr_din;
    logic [1:0]     wr_mask;
    logic [1:0]     ram_we;

    assign req_addr = ldram_en ? idx_addr : pc;
    assign eff_addr = sel_xsp ? xsp : idx_addr;
    assign eff_data = data_sel ? mem_pkg::long_t'(pc) : alu_dout;

    assign hit     = win_ok == 4'hf && win_addr == req_addr;
    assign ram_rdy = hit && !wr_busy && !idx_wr;
    assign dout    = {win_hi, win_lo};

    assign wr_start = cen && idx_wr && !wr_busy;
    assign rd_go    = cen && !wr_busy && !idx_wr;

    // forward moves that keep part of the window
    assign slide1 = req_addr == win_addr + mem_pkg::addr_t'(1) && win_ok[3:1] == 3'b111;
    assign slide2 = req_addr == win_addr + mem_pkg::addr_t'(2) && win_ok[3:2] == 2'b11;
    assign slide3 = req_addr == win_addr + mem_pkg::addr_t'(3) && win_ok[3];

    // which pending bytes live in the word at fetch_addr
    always_comb begin
        mem_pkg::addr_t baddr;
        for (int i = 0; i < 4; i++) begin
            baddr   = win_addr + mem_pkg::addr_t'(i);
            got[i]  = fill[i] && (baddr >> 1) == (fetch_addr >> 1);
            lane[i] = baddr[0] ? bus.dout[15:8] : bus.dout[7:0];
        end
    end

    // number of ram cycles minus one
    always_comb begin
        if (wr_len == mem_pkg::LEN_LONG)
            wr_last = wr_addr[0] ? 2'd2 : 2'd1;
        else if (wr_len == mem_pkg::LEN_WORD)
            wr_last = {1'b0, wr_addr[0]};
        else
            wr_last = 2'd0;
    end

    // lane data per write step with odd bytes replicated
    always_comb begin
        wr_din  = wr_data[15:0];
        wr_mask = 2'b11;
        if (!wr_addr[0]) begin
            if (wr_step == 2'd0) begin
                wr_din  = wr_data[15:0];
                wr_mask = wr_len == mem_pkg::LEN_BYTE ? 2'b01 : 2'b11;
            end else begin
                wr_din  = wr_data[31:16];
                wr_mask = 2'b11;
            end
        end else begin
            case (wr_step)
                2'd0: begin
                    wr_din  = {2{wr_data[7:0]}};
                    wr_mask = 2'b10;
                end
                2'd1: begin
                    if (wr_len == mem_pkg::LEN_WORD) begin
                        wr_din  = {2{wr_data[15:8]}};
                        wr_mask = 2'b01;
                    end else begin
                        wr_din  = wr_data[23:8];
                        wr_mask = 2'b11;
                    end
                end
                default: begin
                    wr_din  = {2{wr_data[31:24]}};
                    wr_mask = 2'b01;
                end
            endcase
        end
    end

    assign ram_we   = (wr_busy && cen) ? wr_mask : 2'b00;
    assign wr_cycle = ram_we != 2'b00;

    assign bus.we   = ram_we;
    assign bus.din  = wr_din;
    assign bus.addr = wr_busy ? wr_addr + mem_pkg::addr_t'({wr_step, 1'b0}) : fetch_addr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_addr   <= '0;
            win_ok     <= 4'h0;
            fill       <= 4'h0;
            fetch_addr <= '0;
            wr_busy    <= 1'b0;
            wr_step    <= 2'd0;
        end else if (cen) begin
            if (wr_start) begin
                wr_busy <= 1'b1;
                wr_step <= 2'd0;
                win_ok  <= 4'h0;   // window may hold old bytes
                fill    <= 4'h0;
            end else if (wr_busy) begin
                if (wr_step == wr_last) begin
                    wr_busy <= 1'b0;
                    wr_step <= 2'd0;
                end else begin
                    wr_step <= wr_step + 2'd1;
                end
            end else if (fill != 4'h0) begin
                win_ok     <= win_ok | got;
                fill       <= fill & ~got;
                fetch_addr <= fetch_addr + mem_pkg::addr_t'(2);
            end else if (!hit) begin
                win_addr <= req_addr;
                if (slide1) begin
                    fetch_addr <= req_addr + mem_pkg::addr_t'(3);
                    fill       <= 4'b1000;
                    win_ok     <= 4'b0111;
                end else if (slide2) begin
                    fetch_addr <= req_addr + mem_pkg::addr_t'(2);
                    fill       <= 4'b1100;
                    win_ok     <= 4'b0011;
                end else if (slide3) begin
                    fetch_addr <= req_addr + mem_pkg::addr_t'(1);
                    fill       <= 4'b1110;
                    win_ok     <= 4'b0001;
                end else begin
                    fetch_addr <= req_addr;   // full reload
                    fill       <= 4'b1111;
                    win_ok     <= 4'b0000;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            wr_addr <= eff_addr;
            wr_data <= eff_data;
            wr_len  <= len;
        end
        if (rd_go) begin
            if (got[0]) win_lo[7:0]  <= lane[0];
            if (got[1]) win_lo[15:8] <= lane[1];
            if (got[2]) win_hi[7:0]  <= lane[2];
            if (got[3]) win_hi[15:8] <= lane[3];
            if (fill == 4'h0 && !hit) begin
                if (slide1)
                    {win_hi, win_lo} <= {8'd0, win_hi, win_lo[15:8]};
                else if (slide2)
                    win_lo <= win_hi;
                else if (slide3)
                    win_lo[7:0] <= win_hi[15:8];
            end
        end
    end

    // strobes stop at the last step of the split
    a_we_in_write: assert property (@(posedge clk) disable iff (rst)
        bus.we != 2'b00 |-> wr_busy && wr_step <= wr_last);

    // window stays empty during a write so ram_rdy cannot rise on old bytes
    a_no_rdy_in_write: assert property (@(posedge clk) disable iff (rst)
        wr_busy |-> win_ok == 4'h0 && fill == 4'h0);

endmodule

/* sources.f */
+incdir+.
mem_pkg.sv
mem_bus_if.sv
ram_ctl.sv
sram16.sv
mem_cfg_apb.sv
mem_top.sv
tb_mem_top.sv

/* sram16.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram16 (
    input  logic   clk,
    mem_bus_if.mem bus
);

    localparam int IW = $clog2(`MEM_DEPTH_WORDS);

    mem_pkg::half_t mem [`MEM_DEPTH_WORDS];
    logic [IW-1:0]  widx;

    assign widx     = bus.addr[IW:1];   // byte address to word index
    assign bus.dout = mem[widx];

    // lanes written on their own
    always_ff @(posedge clk) begin
        if (bus.we[0]) begin
            mem[widx][7:0] <= bus.din[7:0];
        end
        if (bus.we[1]) begin
            mem[widx][15:8] <= bus.din[15:8];
        end
    end

    // writes must not alias into the array
    a_wr_in_range: assert property (@(posedge clk)
        bus.we != 2'b00 |-> bus.addr[`MEM_AW-1:IW+1] == '0);

endmodule

/* tb_mem_top.sv */
`timescale 1ns/1ps
`include "mem_macros.svh"

module tb_mem_top;

    localparam int REGION      = 512;      // preloaded bytes that all tests stay inside
    localparam int CYCLE_LIMIT = 20000;
    localparam mem_pkg::len_t LENS [3] = '{mem_pkg::LEN_BYTE, mem_pkg::LEN_WORD,
                                           mem_pkg::LEN_LONG};

    logic               clk;
    logic               rst;
    mem_pkg::addr_t     pc;
    mem_pkg::addr_t     idx_addr;
    mem_pkg::addr_t     xsp;
    logic               ldram_en;
    logic               sel_xsp;
    logic               data_sel;
    mem_pkg::long_t     alu_dout;
    logic               idx_wr;
    mem_pkg::len_t      len;
    mem_pkg::long_t     dout;
    logic               ram_rdy;
    logic [`CFG_AW-1:0] paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [31:0]        pwdata;
    logic [31:0]        prdata;
    logic               pready;
    logic               pslverr;

    logic [7:0]  model [2*`MEM_DEPTH_WORDS];   // byte image of the ram
    logic [31:0] rng_state;
    int          cycles = 0;
    int          error_count;

    mem_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .pc       (pc),
        .idx_addr (idx_addr),
        .xsp      (xsp),
        .ldram_en (ldram_en),
        .sel_xsp  (sel_xsp),
        .data_sel (data_sel),
        .alu_dout (alu_dout),
        .idx_wr   (idx_wr),
        .len      (len),
        .dout     (dout),
        .ram_rdy  (ram_rdy),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycles <= cycles + 1;

    initial begin : watchdog
        wait (cycles >= CYCLE_LIMIT);
        $display("run exceeded %0d cycles without finishing", CYCLE_LIMIT);
        $display("Errors found");
        $fatal(1, "stopped by timeout");
    end

    task automatic stop_run(input string what);
        error_count++;
        $display("%s", what);
        $display("Errors found");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // preload pattern with upper address bits folded in
    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a * 37) ^ 8'(a >> 5) ^ 8'h5a;
    endfunction

    function automatic mem_pkg::addr_t pick_addr(input logic odd);
        mem_pkg::addr_t a;
        a    = mem_pkg::addr_t'((next_rand() >> 8) % (REGION - 8));
        a[0] = odd;
        return a;
    endfunction

    function automatic int len_bytes(input mem_pkg::len_t l);
        if (l == mem_pkg::LEN_LONG)
            return 4;
        else if (l == mem_pkg::LEN_WORD)
            return 2;
        return 1;
    endfunction

    // ram cycles per access by length and alignment
    function automatic int ram_cycles(input mem_pkg::len_t l, input logic odd);
        if (l == mem_pkg::LEN_LONG)
            return odd ? 3 : 2;
        else if (l == mem_pkg::LEN_WORD)
            return odd ? 2 : 1;
        return 1;
    endfunction

    function automatic void model_write(input mem_pkg::addr_t a, input mem_pkg::long_t d,
                                        input mem_pkg::len_t l);
        for (int i = 0; i < len_bytes(l); i++)
            model[int'(a) + i] = d[8*i +: 8];
    endfunction

    function automatic mem_pkg::long_t model_long(input mem_pkg::addr_t a);
        return {model[int'(a) + 3], model[int'(a) + 2], model[int'(a) + 1], model[int'(a)]};
    endfunction

    task automatic check_long(input string name, input mem_pkg::long_t got,
                              input mem_pkg::long_t exp);
        if (got !== exp)
            stop_run($sformatf("** Error %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic check_addr_data(input logic [`CFG_AW-1:0] a, input logic [31:0] got,
                                   input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("** Error prdata at 0x%02h: got 0x%08h, expected 0x%08h",
                               a, got, exp));
    endtask

    task automatic check_ctrl(input mem_pkg::ctrl_t got, input mem_pkg::ctrl_t exp);
        if (got !== exp)
            stop_run($sformatf(
                "** Error ctrl: got div 0x%0h enable 0x%0h, expected div 0x%0h enable 0x%0h",
                got.div, got.enable, exp.div, exp.enable));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_run($sformatf("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // next drive slot just after the rising edge
    task automatic drive_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic apb_write(input logic [`CFG_AW-1:0] a, input logic [31:0] d);
        drive_edge();
        paddr   = a;
        pwdata  = d;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        drive_edge();
        penable = 1'b1;
        drive_edge();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`CFG_AW-1:0] a, output logic [31:0] d,
                            output logic err);
        drive_edge();
        paddr   = a;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        drive_edge();
        penable = 1'b1;
        @(negedge clk);     // access phase
        d   = prdata;
        err = pslverr;
        check_bit("pready", pready, 1'b1);
        drive_edge();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_ready(input mem_pkg::addr_t a);
        int n;
        n = 0;
        @(negedge clk);
        while (!ram_rdy) begin
            n++;
            if (n > 200)
                stop_run($sformatf("ram_rdy never rose for the request at 0x%06h", a));
            @(negedge clk);
        end
    endtask

    // one write pulse on a cen cycle and a wait for the read side
    task automatic write_cpu(input logic use_xsp, input logic use_pc,
                             input mem_pkg::addr_t a, input mem_pkg::addr_t sp,
                             input mem_pkg::long_t d, input mem_pkg::len_t l);
        mem_pkg::addr_t wa;
        mem_pkg::long_t wd;
        drive_edge();
        while (!dut0.cen)
            drive_edge();
        sel_xsp  = use_xsp;
        data_sel = use_pc;
        idx_addr = a;
        xsp      = sp;
        alu_dout = d;
        len      = l;
        idx_wr   = 1'b1;
        drive_edge();
        idx_wr = 1'b0;
        wa = use_xsp ? sp : a;
        wd = use_pc ? {8'h00, pc} : d;
        model_write(wa, wd, l);
        wait_ready(ldram_en ? idx_addr : pc);
    endtask

    task automatic read_check(input logic use_idx, input mem_pkg::addr_t a);
        drive_edge();
        ldram_en = use_idx;
        if (use_idx)
            idx_addr = a;
        else
            pc = a;
        wait_ready(a);
        check_long("dout", dout, model_long(a));
    endtask

    task automatic preload_ram();
        mem_pkg::long_t d;
        drive_edge();
        ldram_en = 1'b1;
        for (int a = 0; a < REGION; a += 4) begin
            d = {fill_byte(a + 3), fill_byte(a + 2), fill_byte(a + 1), fill_byte(a)};
            write_cpu(1'b0, 1'b0, mem_pkg::addr_t'(a), '0, d, mem_pkg::LEN_LONG);
        end
    endtask

    task automatic apb_registers();
        logic [31:0]    rd;
        logic           err;
        mem_pkg::ctrl_t exp;
        exp.enable = 1'b1;
        exp.div    = 4'd0;
        apb_read(`CFG_CTRL, rd, err);
        check_ctrl(mem_pkg::ctrl_t'(rd[$bits(mem_pkg::ctrl_t)-1:0]), exp);
        check_addr_data(`CFG_CTRL, rd, 32'h0000_0001);
        check_bit("pslverr", err, 1'b0);
        exp.div = 4'd2;
        apb_write(`CFG_CTRL, 32'(exp));
        apb_read(`CFG_CTRL, rd, err);
        check_ctrl(mem_pkg::ctrl_t'(rd[$bits(mem_pkg::ctrl_t)-1:0]), exp);
        check_addr_data(`CFG_CTRL, rd, 32'h0000_0005);   // div 2 in [4:1], enable in [0]
        apb_read(8'h08, rd, err);               // unmapped
        check_bit("pslverr", err, 1'b1);
        check_addr_data(8'h08, rd, 32'h0);
        apb_write(8'h08, 32'h1f);
        apb_read(`CFG_CTRL, rd, err);
        check_addr_data(`CFG_CTRL, rd, 32'h0000_0005);
        apb_write(`CFG_CTRL, 32'h1);            // back to full speed
    endtask

    task automatic length_alignment();
        mem_pkg::addr_t a;
        drive_edge();
        ldram_en = 1'b1;
        for (int k = 0; k < 3; k++) begin
            for (int odd = 0; odd < 2; odd++) begin
                a = pick_addr(odd[0]);
                write_cpu(1'b0, 1'b0, a, '0, next_rand(), LENS[k]);
                read_check(1'b1, a);
            end
        end
    endtask

    task automatic sequential_fetch();
        mem_pkg::addr_t a;
        a = 24'd16;
        for (int i = 0; i < 150; i++) begin
            read_check(1'b0, a);
            a = a + mem_pkg::addr_t'((next_rand() >> 16) % 6);
            if (a > REGION - 8)
                a = mem_pkg::addr_t'((next_rand() >> 8) % 64);   // forces a reload
        end
    endtask

    task automatic write_source_select();
        mem_pkg::addr_t a;
        mem_pkg::addr_t sp;
        a  = mem_pkg::addr_t'((next_rand() >> 8) % 200);
        sp = a + 24'd251;
        drive_edge();
        ldram_en = 1'b1;
        pc       = mem_pkg::addr_t'(next_rand());
        write_cpu(1'b1, 1'b1, a, sp, next_rand(), mem_pkg::LEN_LONG);
        read_check(1'b1, a);
        read_check(1'b1, sp);
        write_cpu(1'b0, 1'b1, a, sp, next_rand(), mem_pkg::LEN_WORD);
        read_check(1'b1, a);
        write_cpu(1'b1, 1'b0, a, sp, next_rand(), mem_pkg::LEN_LONG);
        read_check(1'b1, sp);
        read_check(1'b1, a);
    endtask

    task automatic write_counting();
        mem_pkg::addr_t addrs [6];
        mem_pkg::long_t datas [6];
        mem_pkg::ctrl_t slow;
        logic [31:0]    rd;
        logic           err;
        int             exp_cycles;
        exp_cycles  = 0;
        slow.enable = 1'b1;
        slow.div    = 4'd3;
        for (int k = 0; k < 6; k++) begin
            addrs[k]   = mem_pkg::addr_t'(64 + 16 * k + k % 2);   // odd k is unaligned
            datas[k]   = next_rand();
            exp_cycles += ram_cycles(LENS[k/2], k % 2 == 1);
        end
        for (int pass = 0; pass < 2; pass++) begin
            apb_write(`CFG_CTRL, pass == 0 ? 32'h1 : 32'(slow));
            apb_write(`CFG_WRCNT, 32'h0);
            drive_edge();
            ldram_en = 1'b1;
            for (int k = 0; k < 6; k++)
                write_cpu(1'b0, 1'b0, addrs[k], '0, datas[k], LENS[k/2]);
            apb_read(`CFG_WRCNT, rd, err);
            check_addr_data(`CFG_WRCNT, rd, 32'(exp_cycles));
            for (int k = 0; k < 6; k++)
                read_check(1'b1, addrs[k]);
        end
        apb_write(`CFG_CTRL, 32'h1);
    endtask

    task automatic enable_gating();
        read_check(1'b0, 24'd40);
        apb_write(`CFG_CTRL, 32'h0);
        drive_edge();
        pc = 24'd200;       // miss since the window sits at 40
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (ram_rdy)
                stop_run("ram_rdy rose for a missed fetch while cen was disabled");
        end
        apb_write(`CFG_CTRL, 32'h1);
        wait_ready(pc);
        check_long("dout", dout, model_long(24'd200));
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        pc          = '0;
        idx_addr    = '0;
        xsp         = '0;
        ldram_en    = 1'b0;
        sel_xsp     = 1'b0;
        data_sel    = 1'b0;
        alu_dout    = '0;
        idx_wr      = 1'b0;
        len         = mem_pkg::LEN_BYTE;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        rng_state   = 32'd78488;
        error_count = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        apb_registers();
        preload_ram();
        length_alignment();
        sequential_fetch();
        write_source_select();
        write_counting();
        enable_gating();

        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule
